// File: hdl/bf16_fpu_pkg.sv
// shared bf16 constants and types; only round-to-nearest-even, subnormals are not represented
`default_nettype none

package bf16_fpu_pkg;

    //////////////////////////////
    // word format
    //////////////////////////////

    localparam int BF16_W   = 16;
    localparam int EXP_W    = 8;
    localparam int FRAC_W   = 7;
    // hidden bit included
    localparam int MANT_W   = 8;
    // guard, round, sticky below the mantissa
    localparam int GRS_W    = 3;
    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;
    // signed working exponent, headroom for over/underflow before packing
    localparam int XEXP_W   = 10;
    // leading zero count over a guarded mantissa
    localparam int LZ_W     = $clog2(MANT_W + GRS_W + 1);

    //////////////////////////////
    // special encodings
    //////////////////////////////

    localparam logic [BF16_W-1:0] CANON_QNAN = 16'h7FC0;
    localparam logic [BF16_W-1:0] POS_INF    = 16'h7F80;
    localparam logic [BF16_W-1:0] NEG_INF    = 16'hFF80;

    // operation select
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_MUL = 3'd2,
        OP_EQ  = 3'd3,
        OP_LT  = 3'd4,
        OP_LE  = 3'd5
    } fpu_op_e;

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } bf16_fields_t;

    // raw view for ordering and specials, field view for unpacking
    typedef union packed {
        logic [BF16_W-1:0] raw;
        bf16_fields_t      fld;
    } bf16_u;

endpackage

`default_nettype wire

// File: hdl/bf16_operand_unpack.sv
// splits a bf16 word; subnormals come out as zero of the same sign, NaN payload is ignored
`default_nettype none

module bf16_operand_unpack
    import bf16_fpu_pkg::*;
(
    input  bf16_u             word_i,
    output logic              sign_o,
    output logic [EXP_W-1:0]  exp_o,
    output logic [MANT_W-1:0] mant_o,
    output logic              is_zero_o,
    output logic              is_inf_o,
    output logic              is_nan_o
);

    logic exp_zero;
    logic exp_ones;
    logic frac_zero;

    assign exp_zero  = (word_i.fld.exp == '0);
    assign exp_ones  = (word_i.fld.exp == EXP_W'(EXP_MAX));
    assign frac_zero = (word_i.fld.frac == '0);

    assign sign_o    = word_i.fld.sign;
    // zero exponent covers true zero and flushed subnormals
    assign is_zero_o = exp_zero;
    assign is_inf_o  = exp_ones & frac_zero;
    assign is_nan_o  = exp_ones & ~frac_zero;

    assign exp_o  = word_i.fld.exp;
    // restore hidden bit, zero mantissa for flushed values
    assign mant_o = exp_zero ? '0 : {1'b1, word_i.fld.frac};

endmodule

`default_nettype wire

// File: hdl/bf16_addsub.sv
// bf16 add/sub datapath; mant_o is left-aligned with 3 guard bits, exact zero results flagged special
`default_nettype none

module bf16_addsub
    import bf16_fpu_pkg::*;
(
    input  logic                          is_sub_i,
    input  logic                          sign_a_i,
    input  logic [EXP_W-1:0]              exp_a_i,
    input  logic [MANT_W-1:0]             mant_a_i,
    input  logic                          is_zero_a_i,
    input  logic                          is_inf_a_i,
    input  logic                          is_nan_a_i,
    input  logic                          sign_b_i,
    input  logic [EXP_W-1:0]              exp_b_i,
    input  logic [MANT_W-1:0]             mant_b_i,
    input  logic                          is_zero_b_i,
    input  logic                          is_inf_b_i,
    input  logic                          is_nan_b_i,
    output logic                          sign_o,
    output logic signed [XEXP_W-1:0]      exp_o,
    output logic [MANT_W+GRS_W-1:0]       mant_o,
    output logic                          is_special_o,
    output logic [BF16_W-1:0]             special_val_o
);

    logic                          sign_b_eff;
    logic                          a_ge_b;
    logic                          sign_big;
    logic                          sign_small;
    logic [EXP_W-1:0]              exp_big;
    logic [EXP_W-1:0]              exp_diff;
    logic [MANT_W-1:0]             mant_big;
    logic [MANT_W-1:0]             mant_small;
    logic [EXP_W-1:0]              shamt;
    logic [2*(MANT_W+GRS_W)-1:0]   small_wide;
    logic [MANT_W+GRS_W-1:0]       small_al;
    logic [MANT_W+GRS_W:0]         sum;
    logic [LZ_W-1:0]               lz;
    logic                          cancel;

    //////////////////////////////
    // operand ordering
    //////////////////////////////

    // subtract is add with b negated
    assign sign_b_eff = sign_b_i ^ is_sub_i;
    assign a_ge_b     = {exp_a_i, mant_a_i} >= {exp_b_i, mant_b_i};

    assign sign_big   = a_ge_b ? sign_a_i : sign_b_eff;
    assign sign_small = a_ge_b ? sign_b_eff : sign_a_i;
    assign exp_big    = a_ge_b ? exp_a_i : exp_b_i;
    assign exp_diff   = a_ge_b ? (exp_a_i - exp_b_i) : (exp_b_i - exp_a_i);
    assign mant_big   = a_ge_b ? mant_a_i : mant_b_i;
    assign mant_small = a_ge_b ? mant_b_i : mant_a_i;

    // beyond the guarded width everything lands in sticky
    assign shamt = (exp_diff > EXP_W'(MANT_W + GRS_W)) ? EXP_W'(MANT_W + GRS_W) : exp_diff;

    assign small_wide = {mant_small, {(MANT_W + 2*GRS_W){1'b0}}} >> shamt;
    assign small_al   = {small_wide[2*(MANT_W+GRS_W)-1 -: MANT_W+GRS_W-1],
                         small_wide[MANT_W+GRS_W] | (|small_wide[MANT_W+GRS_W-1:0])};

    assign sum = (sign_big ^ sign_small) ? {1'b0, mant_big, {GRS_W{1'b0}}} - {1'b0, small_al}
                                         : {1'b0, mant_big, {GRS_W{1'b0}}} + {1'b0, small_al};

    assign cancel = (sum == '0);

    //////////////////////////////
    // normalisation
    //////////////////////////////

    always_comb begin
        lz = '0;
        // last hit is the most significant one
        for (int i = 0; i < MANT_W + GRS_W; i++) begin
            if (sum[i]) begin
                lz = LZ_W'(MANT_W + GRS_W - 1 - i);
            end
        end
    end

    always_comb begin
        sign_o = sign_big;
        if (sum[MANT_W+GRS_W]) begin
            // carry out, shift right keeping sticky
            mant_o = {sum[MANT_W+GRS_W:2], sum[1] | sum[0]};
            exp_o  = XEXP_W'(exp_big) + XEXP_W'(1);
        end else begin
            mant_o = sum[MANT_W+GRS_W-1:0] << lz;
            exp_o  = XEXP_W'(exp_big) - XEXP_W'(lz);
        end
    end

    //////////////////////////////
    // special results
    //////////////////////////////

    always_comb begin
        is_special_o = 1'b1;
        if (is_nan_a_i | is_nan_b_i | (is_inf_a_i & is_inf_b_i & (sign_a_i ^ sign_b_eff))) begin
            special_val_o = CANON_QNAN;
        end else if (is_inf_a_i) begin
            special_val_o = sign_a_i ? NEG_INF : POS_INF;
        end else if (is_inf_b_i) begin
            special_val_o = sign_b_eff ? NEG_INF : POS_INF;
        end else if (cancel) begin
            // only -0 + -0 keeps the minus sign
            special_val_o = {is_zero_a_i & is_zero_b_i & sign_a_i & sign_b_eff,
                             {(BF16_W-1){1'b0}}};
        end else begin
            is_special_o  = 1'b0;
            special_val_o = '0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/bf16_mul.sv
// bf16 multiply datapath; exponent is unbounded here, range limits are applied when packing
`default_nettype none

module bf16_mul
    import bf16_fpu_pkg::*;
(
    input  logic                          sign_a_i,
    input  logic [EXP_W-1:0]              exp_a_i,
    input  logic [MANT_W-1:0]             mant_a_i,
    input  logic                          is_zero_a_i,
    input  logic                          is_inf_a_i,
    input  logic                          is_nan_a_i,
    input  logic                          sign_b_i,
    input  logic [EXP_W-1:0]              exp_b_i,
    input  logic [MANT_W-1:0]             mant_b_i,
    input  logic                          is_zero_b_i,
    input  logic                          is_inf_b_i,
    input  logic                          is_nan_b_i,
    output logic                          sign_o,
    output logic signed [XEXP_W-1:0]      exp_o,
    output logic [MANT_W+GRS_W-1:0]       mant_o,
    output logic                          is_special_o,
    output logic [BF16_W-1:0]             special_val_o
);

    logic [2*MANT_W-1:0] prod;
    logic                top;

    assign prod   = mant_a_i * mant_b_i;
    // product of two 1.x values lies in [1, 4)
    assign top    = prod[2*MANT_W-1];
    assign sign_o = sign_a_i ^ sign_b_i;

    assign exp_o = XEXP_W'(exp_a_i) + XEXP_W'(exp_b_i) - XEXP_W'(EXP_BIAS) + XEXP_W'(top);

    // keep 10 bits, fold the rest into sticky
    assign mant_o = top ? {prod[2*MANT_W-1 -: MANT_W+GRS_W-1], |prod[MANT_W-GRS_W:0]}
                        : {prod[2*MANT_W-2 -: MANT_W+GRS_W-1], |prod[MANT_W-GRS_W-1:0]};

    //////////////////////////////
    // special results
    //////////////////////////////

    always_comb begin
        is_special_o = 1'b1;
        if (is_nan_a_i | is_nan_b_i | (is_inf_a_i & is_zero_b_i) | (is_zero_a_i & is_inf_b_i)) begin
            special_val_o = CANON_QNAN;
        end else if (is_inf_a_i | is_inf_b_i) begin
            special_val_o = sign_o ? NEG_INF : POS_INF;
        end else if (is_zero_a_i | is_zero_b_i) begin
            special_val_o = {sign_o, {(BF16_W-1){1'b0}}};
        end else begin
            is_special_o  = 1'b0;
            special_val_o = '0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/bf16_cmp.sv
// bf16 compare; +0 equals -0, subnormals count as zero, any NaN operand answers 0
`default_nettype none

module bf16_cmp
    import bf16_fpu_pkg::*;
(
    input  fpu_op_e opcode_i,
    input  logic    sign_a_i,
    input  logic    is_zero_a_i,
    input  logic    is_nan_a_i,
    input  bf16_u   a_i,
    input  logic    sign_b_i,
    input  logic    is_zero_b_i,
    input  logic    is_nan_b_i,
    input  bf16_u   b_i,
    output logic    lt_eq_o
);

    logic [BF16_W-2:0] mag_a;
    logic [BF16_W-2:0] mag_b;
    logic              both_zero;
    logic              eq;
    logic              lt;

    // flushed values order as zero
    assign mag_a     = is_zero_a_i ? '0 : a_i.raw[BF16_W-2:0];
    assign mag_b     = is_zero_b_i ? '0 : b_i.raw[BF16_W-2:0];
    assign both_zero = is_zero_a_i & is_zero_b_i;

    assign eq = both_zero | ((mag_a == mag_b) & (sign_a_i == sign_b_i));

    always_comb begin
        if (both_zero) begin
            lt = 1'b0;
        end else if (sign_a_i != sign_b_i) begin
            lt = sign_a_i;
        end else begin
            // negative values order by reversed magnitude
            lt = sign_a_i ? (mag_a > mag_b) : (mag_a < mag_b);
        end
    end

    always_comb begin
        case (opcode_i)
            OP_EQ:   lt_eq_o = eq;
            OP_LT:   lt_eq_o = lt;
            OP_LE:   lt_eq_o = lt | eq;
            default: lt_eq_o = 1'b0;
        endcase
        if (is_nan_a_i | is_nan_b_i) begin
            lt_eq_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/bf16_round_pack.sv
// round-to-nearest-even and pack; expects mant_i normalised with its leading one at the top bit
`default_nettype none

module bf16_round_pack
    import bf16_fpu_pkg::*;
(
    input  logic                        sign_i,
    input  logic signed [XEXP_W-1:0]    exp_i,
    input  logic [MANT_W+GRS_W-1:0]     mant_i,
    output bf16_u                       word_o
);

    logic                     guard;
    logic                     rest;
    logic                     lsb;
    logic                     round_up;
    logic [MANT_W:0]          rounded;
    logic signed [XEXP_W-1:0] exp_r;
    logic [FRAC_W-1:0]        frac_r;

    assign lsb   = mant_i[GRS_W];
    assign guard = mant_i[GRS_W-1];
    assign rest  = |mant_i[GRS_W-2:0];

    // ties go to the even mantissa
    assign round_up = guard & (rest | lsb);
    assign rounded  = {1'b0, mant_i[MANT_W+GRS_W-1:GRS_W]} + (MANT_W+1)'(round_up);

    // carry out of rounding bumps the exponent
    assign exp_r  = exp_i + XEXP_W'(rounded[MANT_W]);
    // a carry out leaves the fraction bits at zero
    assign frac_r = rounded[FRAC_W-1:0];

    always_comb begin
        if (exp_r >= EXP_MAX) begin
            word_o.raw = sign_i ? NEG_INF : POS_INF;
        end else if (exp_r <= 0) begin
            // flush below the normal range
            word_o.raw = {sign_i, {(BF16_W-1){1'b0}}};
        end else begin
            word_o.fld.sign = sign_i;
            word_o.fld.exp  = exp_r[EXP_W-1:0];
            word_o.fld.frac = frac_r;
        end
    end

endmodule

`default_nettype wire

// File: hdl/bf16_fpu.sv
// bf16 FPU top; one operation per clock, result one cycle after valid_i, no back-pressure
`default_nettype none

module bf16_fpu
    import bf16_fpu_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    input  logic              valid_i,
    input  fpu_op_e           opcode_i,
    input  logic [BF16_W-1:0] op_a_i,
    input  logic [BF16_W-1:0] op_b_i,
    output logic [BF16_W-1:0] result_o,
    output logic              result_valid_o
);

    bf16_u                    word_a;
    bf16_u                    word_b;
    logic                     sign_a, zero_a, inf_a, nan_a;
    logic                     sign_b, zero_b, inf_b, nan_b;
    logic [EXP_W-1:0]         exp_a, exp_b;
    logic [MANT_W-1:0]        mant_a, mant_b;

    logic                     as_sign, mul_sign, rp_sign;
    logic signed [XEXP_W-1:0] as_exp, mul_exp, rp_exp;
    logic [MANT_W+GRS_W-1:0]  as_mant, mul_mant, rp_mant;
    logic                     as_special, mul_special, sel_special;
    logic [BF16_W-1:0]        as_special_val, mul_special_val, sel_special_val;

    logic                     use_mul;
    logic                     cmp_bit;
    bf16_u                    packed_word;
    logic [BF16_W-1:0]        result_d;

    assign word_a.raw = op_a_i;
    assign word_b.raw = op_b_i;

    bf16_operand_unpack u_unpack_a (
        .word_i(word_a), .sign_o(sign_a), .exp_o(exp_a), .mant_o(mant_a),
        .is_zero_o(zero_a), .is_inf_o(inf_a), .is_nan_o(nan_a)
    );

    bf16_operand_unpack u_unpack_b (
        .word_i(word_b), .sign_o(sign_b), .exp_o(exp_b), .mant_o(mant_b),
        .is_zero_o(zero_b), .is_inf_o(inf_b), .is_nan_o(nan_b)
    );

    //////////////////////////////
    // arithmetic paths
    //////////////////////////////

    bf16_addsub u_addsub (
        .is_sub_i(opcode_i == OP_SUB),
        .sign_a_i(sign_a), .exp_a_i(exp_a), .mant_a_i(mant_a),
        .is_zero_a_i(zero_a), .is_inf_a_i(inf_a), .is_nan_a_i(nan_a),
        .sign_b_i(sign_b), .exp_b_i(exp_b), .mant_b_i(mant_b),
        .is_zero_b_i(zero_b), .is_inf_b_i(inf_b), .is_nan_b_i(nan_b),
        .sign_o(as_sign), .exp_o(as_exp), .mant_o(as_mant),
        .is_special_o(as_special), .special_val_o(as_special_val)
    );

    bf16_mul u_mul (
        .sign_a_i(sign_a), .exp_a_i(exp_a), .mant_a_i(mant_a),
        .is_zero_a_i(zero_a), .is_inf_a_i(inf_a), .is_nan_a_i(nan_a),
        .sign_b_i(sign_b), .exp_b_i(exp_b), .mant_b_i(mant_b),
        .is_zero_b_i(zero_b), .is_inf_b_i(inf_b), .is_nan_b_i(nan_b),
        .sign_o(mul_sign), .exp_o(mul_exp), .mant_o(mul_mant),
        .is_special_o(mul_special), .special_val_o(mul_special_val)
    );

    bf16_cmp u_cmp (
        .opcode_i(opcode_i),
        .sign_a_i(sign_a), .is_zero_a_i(zero_a), .is_nan_a_i(nan_a), .a_i(word_a),
        .sign_b_i(sign_b), .is_zero_b_i(zero_b), .is_nan_b_i(nan_b), .b_i(word_b),
        .lt_eq_o(cmp_bit)
    );

    // one rounder shared by both paths
    assign use_mul         = (opcode_i == OP_MUL);
    assign rp_sign         = use_mul ? mul_sign : as_sign;
    assign rp_exp          = use_mul ? mul_exp : as_exp;
    assign rp_mant         = use_mul ? mul_mant : as_mant;
    assign sel_special     = use_mul ? mul_special : as_special;
    assign sel_special_val = use_mul ? mul_special_val : as_special_val;

    bf16_round_pack u_round_pack (
        .sign_i(rp_sign), .exp_i(rp_exp), .mant_i(rp_mant), .word_o(packed_word)
    );

    //////////////////////////////
    // result select and register
    //////////////////////////////

    always_comb begin
        case (opcode_i)
            OP_ADD, OP_SUB, OP_MUL: result_d = sel_special ? sel_special_val : packed_word.raw;
            OP_EQ, OP_LT, OP_LE:    result_d = {{(BF16_W-1){1'b0}}, cmp_bit};
            default:                result_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            result_o       <= '0;
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= valid_i;
            // hold last result between strobes
            if (valid_i) begin
                result_o <= result_d;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/bf16_fpu_tb.sv
// testbench for bf16_fpu; vectors come from bench/bf16_fpu_patterns.txt, run from the project root
`default_nettype none

module bf16_fpu_tb
    import bf16_fpu_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          MAX_VECTORS = 64;
    localparam int          DRAIN_LIMIT = 20;
    localparam int unsigned RAND_SEED   = 32'h43cc_c14a;

    logic        clk;
    logic        reset;
    logic        valid;
    fpu_op_e     opcode;
    logic [15:0] op_a;
    logic [15:0] op_b;
    logic [15:0] result;
    logic        result_valid;

    // opcode, a, b and expected result per vector
    logic [15:0] pattern_mem [0:4*MAX_VECTORS-1];
    logic [15:0] expected_q[$];
    int          issue_cycle_q[$];
    int          vector_q[$];
    int          cycle_count;
    logic        issued_any;

    bf16_fpu DUT (
        .clk(clk), .reset_i(reset), .valid_i(valid), .opcode_i(opcode),
        .op_a_i(op_a), .op_b_i(op_b), .result_o(result), .result_valid_o(result_valid)
    );

    always #10 clk = ~clk;

    //////////////////////////////
    // error reporting and checks
    //////////////////////////////

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        if (got !== expected) begin
            stop_on_error($sformatf("FAILED %s: got 0x%04h, expected 0x%04h",
                                    name, got, expected));
        end
    endtask

    // outputs change on the rising edge, so they are stable here
    task automatic check_output();
        logic [15:0] exp_word;
        int          exp_cycle;
        int          idx;
        if (!issued_any) begin
            check_value("result_valid_o", 16'(result_valid), 16'h0000);
            check_value("result_o", result, 16'h0000);
        end
        if (result_valid) begin
            if (expected_q.size() == 0) begin
                stop_on_error("result_valid_o pulsed with no operation outstanding");
            end
            exp_word  = expected_q.pop_front();
            exp_cycle = issue_cycle_q.pop_front();
            idx       = vector_q.pop_front();
            if (cycle_count != exp_cycle + 1) begin
                stop_on_error($sformatf("result of vector %0d came %0d cycles after issue",
                                        idx, cycle_count - exp_cycle));
            end
            check_value($sformatf("result_o (vector %0d)", idx), result, exp_word);
        end else if (issue_cycle_q.size() != 0 && issue_cycle_q[0] + 1 <= cycle_count) begin
            stop_on_error($sformatf("no result for vector %0d one cycle after issue",
                                    vector_q[0]));
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic step_cycle();
        @(negedge clk);
        cycle_count++;
        check_output();
    endtask

    task automatic issue_vector(input int idx);
        valid  = 1'b1;
        opcode = fpu_op_e'(pattern_mem[4*idx][2:0]);
        op_a   = pattern_mem[4*idx+1];
        op_b   = pattern_mem[4*idx+2];
        expected_q.push_back(pattern_mem[4*idx+3]);
        issue_cycle_q.push_back(cycle_count);
        vector_q.push_back(idx);
        issued_any = 1'b1;
    endtask

    initial begin
        int unsigned seed_val;
        int          num_vectors;
        int          gap;
        int          wait_cycles;
        clk         = 1'b0;
        reset       = 1'b1;
        valid       = 1'b0;
        opcode      = OP_ADD;
        op_a        = '0;
        op_b        = '0;
        cycle_count = 0;
        issued_any  = 1'b0;
        seed_val    = $urandom(RAND_SEED);

        $readmemh("bench/bf16_fpu_patterns.txt", pattern_mem);
        num_vectors = 0;
        while (num_vectors < MAX_VECTORS && !$isunknown(pattern_mem[4*num_vectors])) begin
            num_vectors++;
        end
        if (num_vectors == 0) begin
            stop_on_error("pattern file held no vectors");
        end

        repeat (10) step_cycle();
        reset = 1'b0;
        // outputs must stay quiet until the first strobe
        repeat (3) step_cycle();

        for (int i = 0; i < num_vectors; i++) begin
            // first vectors always back to back
            if (i < 4 || $urandom % 2 == 0) begin
                gap = 0;
            end else begin
                gap = $urandom % 4;
            end
            repeat (gap) begin
                step_cycle();
                valid = 1'b0;
            end
            step_cycle();
            issue_vector(i);
        end

        wait_cycles = 0;
        while (expected_q.size() != 0) begin
            if (wait_cycles >= DRAIN_LIMIT) begin
                stop_on_error($sformatf("timeout with %0d results outstanding",
                                        expected_q.size()));
            end
            step_cycle();
            valid = 1'b0;
            wait_cycles++;
        end
        // no stray pulses once drained
        repeat (3) step_cycle();

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/bf16_fpu_patterns.txt
// columns: opcode (0 add, 1 sub, 2 mul, 3 eq, 4 lt, 5 le), operand a, operand b, expected
// all words in hex; compares expect 0001 or 0000
0 3F80 4000 4040
0 3FC0 3FC0 4040
1 4040 3F80 4000
0 4040 BF00 4020
0 C000 3F80 BF80
0 3F80 3B80 3F80
0 3F81 3B80 3F82
1 4040 4040 0000
0 3F80 BF80 0000
1 7F80 7F80 7FC0
0 7F80 FF80 7FC0
0 7F80 3F80 7F80
2 4000 4040 40C0
2 3FC0 3FC0 4010
2 BF80 4000 C000
2 7F00 4000 7F80
2 FF00 4000 FF80
2 0080 3F00 0000
2 8080 3F00 8000
2 0000 7F80 7FC0
2 0001 4000 0000
2 0040 C000 8000
2 7FC1 3F80 7FC0
3 0000 8000 0001
4 8000 0000 0000
5 8000 0000 0001
4 BF80 3F80 0001
4 3F80 BF80 0000
5 C000 BF80 0001
4 BF80 C000 0000
3 3F80 3F80 0001
3 7FC0 7FC0 0000
5 7FC1 3F80 0000
4 3F80 7F80 0001

// File: verilog.f
hdl/bf16_fpu_pkg.sv
hdl/bf16_operand_unpack.sv
hdl/bf16_addsub.sv
hdl/bf16_mul.sv
hdl/bf16_cmp.sv
hdl/bf16_round_pack.sv
hdl/bf16_fpu.sv
bench/bf16_fpu_tb.sv

// File: Bender.yml
package:
  name: bf16_fpu

sources:
  - files:
      - hdl/bf16_fpu_pkg.sv
      - hdl/bf16_operand_unpack.sv
      - hdl/bf16_addsub.sv
      - hdl/bf16_mul.sv
      - hdl/bf16_cmp.sv
      - hdl/bf16_round_pack.sv
      - hdl/bf16_fpu.sv
  - target: test
    files:
      - bench/bf16_fpu_tb.sv
